// ==== hw/dataMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
	input  wire                 Clk,
	input  wire                 writeEn,
	input  wire  mipsPkg::wordT addr,
	input  wire  mipsPkg::wordT writeData,
	output mipsPkg::wordT       readData
);

	mipsPkg::wordT mem [mipsPkg::DMEM_WORDS];
	logic [mipsPkg::DMEM_INDEX_WIDTH-1:0] index;

	// Word index, byte offset ignored
	assign index = addr[mipsPkg::DMEM_INDEX_WIDTH+1:2];

	always_ff @(posedge Clk) begin
		if (writeEn) begin
			mem[index] <= writeData;
		end
	end

	assign readData = mem[index];

endmodule

`default_nettype wire

// ==== hw/decodeUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeUnit (
	input  wire  mipsPkg::wordT   instr,
	input  wire  mipsPkg::wordT   pcPlus4,
	output mipsPkg::ctrlT         ctrl,
	output mipsPkg::wordT         immExt,
	output mipsPkg::regAddrT      rs,
	output mipsPkg::regAddrT      rt,
	output logic                  jumpTaken,
	output mipsPkg::wordT         jumpTarget
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	mipsPkg::regAddrT rd;
	logic signExt;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign imm = instr[15:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	assign immExt = signExt ? {{16{imm[15]}}, imm} : {16'b0, imm};

	assign jumpTaken = (opcode == mipsPkg::OP_J);
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

	always_comb begin
		ctrl = '0;
		signExt = 1'b1;
		case (opcode)
			mipsPkg::OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rd;
				case (funct)
					mipsPkg::FN_ADD, mipsPkg::FN_ADDU: ctrl.aluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB, mipsPkg::FN_SUBU: ctrl.aluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND:  ctrl.aluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR:   ctrl.aluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_XOR:  ctrl.aluOp = mipsPkg::ALU_XOR;
					mipsPkg::FN_NOR:  ctrl.aluOp = mipsPkg::ALU_NOR;
					mipsPkg::FN_SLT:  ctrl.aluOp = mipsPkg::ALU_SLT;
					mipsPkg::FN_SLTU: ctrl.aluOp = mipsPkg::ALU_SLTU;
					mipsPkg::FN_SLL, mipsPkg::FN_SLLV: ctrl.aluOp = mipsPkg::ALU_SLL;
					mipsPkg::FN_SRL, mipsPkg::FN_SRLV: ctrl.aluOp = mipsPkg::ALU_SRL;
					mipsPkg::FN_SRA, mipsPkg::FN_SRAV: ctrl.aluOp = mipsPkg::ALU_SRA;
					default: ctrl = '0;
				endcase
				// Shifts operate on rt
				case (funct)
					mipsPkg::FN_SLL, mipsPkg::FN_SRL, mipsPkg::FN_SRA: begin
						ctrl.aSel = mipsPkg::A_RT;
						ctrl.bSel = mipsPkg::B_SHAMT;
					end
					mipsPkg::FN_SLLV, mipsPkg::FN_SRLV, mipsPkg::FN_SRAV: begin
						ctrl.aSel = mipsPkg::A_RT;
						ctrl.bSel = mipsPkg::B_RSLOW;
					end
					default: begin
						ctrl.aSel = mipsPkg::A_RS;
					end
				endcase
			end
			mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.bSel = mipsPkg::B_IMM;
				ctrl.aluOp = mipsPkg::ALU_ADD;
			end
			mipsPkg::OP_SLTI, mipsPkg::OP_SLTIU: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.bSel = mipsPkg::B_IMM;
				// SLTIU still sign extends, then compares unsigned
				ctrl.aluOp = (opcode == mipsPkg::OP_SLTI) ? mipsPkg::ALU_SLT : mipsPkg::ALU_SLTU;
			end
			mipsPkg::OP_ANDI, mipsPkg::OP_ORI, mipsPkg::OP_XORI: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.bSel = mipsPkg::B_IMM;
				signExt = 1'b0;
				if (opcode == mipsPkg::OP_ANDI) begin
					ctrl.aluOp = mipsPkg::ALU_AND;
				end else if (opcode == mipsPkg::OP_ORI) begin
					ctrl.aluOp = mipsPkg::ALU_OR;
				end else begin
					ctrl.aluOp = mipsPkg::ALU_XOR;
				end
			end
			mipsPkg::OP_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.bSel = mipsPkg::B_IMM;
				ctrl.aluOp = mipsPkg::ALU_LUI;
			end
			mipsPkg::OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.destReg = rt;
				ctrl.bSel = mipsPkg::B_IMM; // Base plus offset
			end
			mipsPkg::OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.bSel = mipsPkg::B_IMM;
			end
			mipsPkg::OP_BEQ: ctrl.branchEq = 1'b1;
			mipsPkg::OP_BNE: ctrl.branchNe = 1'b1;
			default: ctrl = '0; // J needs no control, unknowns become NOPs
		endcase
		if (ctrl.destReg == '0) begin
			ctrl.regWrite = 1'b0; // r0 is never written
		end
	end

endmodule

`default_nettype wire

// ==== hw/executeUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
	input  wire  mipsPkg::idExT stage,
	output mipsPkg::wordT       result,
	output logic                branchTaken,
	output mipsPkg::wordT       branchTarget
);

	mipsPkg::wordT opA;
	mipsPkg::wordT opB;
	logic [4:0] shiftAmt;
	logic operandsEqual;

	assign opA = (stage.ctrl.aSel == mipsPkg::A_RT) ? stage.rtData : stage.rsData;

	always_comb begin
		case (stage.ctrl.bSel)
			mipsPkg::B_IMM:   opB = stage.immExt;
			mipsPkg::B_SHAMT: opB = {27'b0, stage.shamt};
			mipsPkg::B_RSLOW: opB = {27'b0, stage.rsData[4:0]};
			default:          opB = stage.rtData;
		endcase
	end

	assign shiftAmt = opB[4:0];

	always_comb begin
		case (stage.ctrl.aluOp)
			mipsPkg::ALU_ADD:  result = opA + opB;
			mipsPkg::ALU_SUB:  result = opA - opB;
			mipsPkg::ALU_AND:  result = opA & opB;
			mipsPkg::ALU_OR:   result = opA | opB;
			mipsPkg::ALU_XOR:  result = opA ^ opB;
			mipsPkg::ALU_NOR:  result = ~(opA | opB);
			mipsPkg::ALU_SLT:  result = {31'b0, $signed(opA) < $signed(opB)};
			mipsPkg::ALU_SLTU: result = {31'b0, opA < opB};
			mipsPkg::ALU_SLL:  result = opA << shiftAmt;
			mipsPkg::ALU_SRL:  result = opA >> shiftAmt;
			mipsPkg::ALU_SRA:  result = $signed(opA) >>> shiftAmt;
			mipsPkg::ALU_LUI:  result = {opB[15:0], 16'b0};
			default:           result = '0;
		endcase
	end

	// Compare registers directly, the ALU stays free
	assign operandsEqual = (stage.rsData == stage.rtData);
	assign branchTaken = (stage.ctrl.branchEq & operandsEqual)
		| (stage.ctrl.branchNe & ~operandsEqual);

	assign branchTarget = stage.pcPlus4 + {stage.immExt[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
	input  wire                 Clk,
	input  wire                 reset,
	input  wire                 jumpTaken,
	input  wire  mipsPkg::wordT jumpTarget,
	input  wire                 branchTaken,
	input  wire  mipsPkg::wordT branchTarget,
	output mipsPkg::wordT       pc,
	output mipsPkg::wordT       pcPlus4
);

	mipsPkg::wordT pcNext;

	assign pcPlus4 = pc + 32'd4;

	// Branch sits in EX and is older than a jump in ID
	always_comb begin
		if (branchTaken) begin
			pcNext = branchTarget;
		end else if (jumpTaken) begin
			pcNext = jumpTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

	localparam int DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int SHAMT_WIDTH = 5;
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_INDEX_WIDTH = $clog2(DMEM_WORDS);

	// Opcodes
	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_J     = 6'd2;
	localparam logic [5:0] OP_BEQ   = 6'd4;
	localparam logic [5:0] OP_BNE   = 6'd5;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_ADDIU = 6'd9;
	localparam logic [5:0] OP_SLTI  = 6'd10;
	localparam logic [5:0] OP_SLTIU = 6'd11;
	localparam logic [5:0] OP_ANDI  = 6'd12;
	localparam logic [5:0] OP_ORI   = 6'd13;
	localparam logic [5:0] OP_XORI  = 6'd14;
	localparam logic [5:0] OP_LUI   = 6'd15;
	localparam logic [5:0] OP_LW    = 6'd35;
	localparam logic [5:0] OP_SW    = 6'd43;

	// Function codes for R-type
	localparam logic [5:0] FN_SLL  = 6'd0;
	localparam logic [5:0] FN_SRL  = 6'd2;
	localparam logic [5:0] FN_SRA  = 6'd3;
	localparam logic [5:0] FN_SLLV = 6'd4;
	localparam logic [5:0] FN_SRLV = 6'd6;
	localparam logic [5:0] FN_SRAV = 6'd7;
	localparam logic [5:0] FN_ADD  = 6'd32;
	localparam logic [5:0] FN_ADDU = 6'd33;
	localparam logic [5:0] FN_SUB  = 6'd34;
	localparam logic [5:0] FN_SUBU = 6'd35;
	localparam logic [5:0] FN_AND  = 6'd36;
	localparam logic [5:0] FN_OR   = 6'd37;
	localparam logic [5:0] FN_XOR  = 6'd38;
	localparam logic [5:0] FN_NOR  = 6'd39;
	localparam logic [5:0] FN_SLT  = 6'd42;
	localparam logic [5:0] FN_SLTU = 6'd43;

	typedef logic [DATA_WIDTH-1:0] wordT;
	typedef logic [REG_ADDR_WIDTH-1:0] regAddrT;
	typedef logic [SHAMT_WIDTH-1:0] shamtT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} aluOpT;

	typedef enum logic {A_RS, A_RT} aSelT; // A_RT for shifts

	typedef enum logic [1:0] {B_RT, B_IMM, B_SHAMT, B_RSLOW} bSelT;

	typedef struct packed {
		aluOpT   aluOp;
		aSelT    aSel;
		bSelT    bSel;
		logic    regWrite;
		logic    memRead;
		logic    memWrite;
		logic    branchEq;
		logic    branchNe;
		regAddrT destReg;
	} ctrlT;

	typedef struct packed {
		ctrlT  ctrl;
		wordT  pcPlus4;
		wordT  rsData;
		wordT  rtData;
		wordT  immExt;
		shamtT shamt;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		wordT aluResult;
		wordT storeData;
	} exMemT;

	typedef struct packed {
		logic    regWrite;
		logic    memRead;
		regAddrT destReg;
		wordT    aluResult;
		wordT    loadData;
	} memWbT;

endpackage

`default_nettype wire

// ==== hw/pipelineCpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipelineCpu (
	input  wire                 Clk,
	input  wire                 reset,
	input  wire  mipsPkg::wordT imemData,
	output mipsPkg::wordT       imemAddr,
	output logic                wbValid,
	output mipsPkg::regAddrT    wbReg,
	output mipsPkg::wordT       wbData
);

	typedef struct packed {
		mipsPkg::wordT instr;
		mipsPkg::wordT pcPlus4;
	} ifIdT;

	ifIdT ifId;
	mipsPkg::idExT idEx;
	mipsPkg::idExT idExNext;
	mipsPkg::exMemT exMem;
	mipsPkg::memWbT memWb;

	mipsPkg::wordT pc;
	mipsPkg::wordT pcPlus4;
	logic jumpTaken;
	mipsPkg::wordT jumpTarget;
	logic branchTaken;
	mipsPkg::wordT branchTarget;

	mipsPkg::ctrlT decCtrl;
	mipsPkg::wordT immExt;
	mipsPkg::regAddrT rsAddr;
	mipsPkg::regAddrT rtAddr;
	mipsPkg::wordT rsData;
	mipsPkg::wordT rtData;

	mipsPkg::wordT exResult;
	mipsPkg::wordT dmemReadData;

	fetchUnit i_fetch (
		.Clk         (Clk),
		.reset       (reset),
		.jumpTaken   (jumpTaken),
		.jumpTarget  (jumpTarget),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget),
		.pc          (pc),
		.pcPlus4     (pcPlus4)
	);

	assign imemAddr = pc;

	// IF/ID, squashed by a jump in ID or a taken branch in EX
	always_ff @(posedge Clk) begin
		ifId.pcPlus4 <= pcPlus4;
		if (reset || jumpTaken || branchTaken) begin
			ifId.instr <= '0;
		end else begin
			ifId.instr <= imemData;
		end
	end

	decodeUnit i_decode (
		.instr     (ifId.instr),
		.pcPlus4   (ifId.pcPlus4),
		.ctrl      (decCtrl),
		.immExt    (immExt),
		.rs        (rsAddr),
		.rt        (rtAddr),
		.jumpTaken (jumpTaken),
		.jumpTarget(jumpTarget)
	);

	registerFile i_regs (
		.Clk      (Clk),
		.rs       (rsAddr),
		.rt       (rtAddr),
		.writeEn  (wbValid),
		.writeReg (wbReg),
		.writeData(wbData),
		.rsData   (rsData),
		.rtData   (rtData)
	);

	always_comb begin
		idExNext.ctrl = decCtrl;
		idExNext.pcPlus4 = ifId.pcPlus4;
		idExNext.rsData = rsData;
		idExNext.rtData = rtData;
		idExNext.immExt = immExt;
		idExNext.shamt = ifId.instr[10:6];
	end

	always_ff @(posedge Clk) begin
		idEx <= idExNext;
		if (reset || branchTaken) begin
			idEx.ctrl <= '0; // Only the control bundle needs clearing
		end
	end

	executeUnit i_execute (
		.stage       (idEx),
		.result      (exResult),
		.branchTaken (branchTaken),
		.branchTarget(branchTarget)
	);

	always_ff @(posedge Clk) begin
		exMem.aluResult <= exResult;
		exMem.storeData <= idEx.rtData;
		if (reset) begin
			exMem.ctrl <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
		end
	end

	dataMemory i_dmem (
		.Clk      (Clk),
		.writeEn  (exMem.ctrl.memWrite),
		.addr     (exMem.aluResult),
		.writeData(exMem.storeData),
		.readData (dmemReadData)
	);

	always_ff @(posedge Clk) begin
		memWb.destReg <= exMem.ctrl.destReg;
		memWb.aluResult <= exMem.aluResult;
		memWb.loadData <= dmemReadData;
		if (reset) begin
			memWb.regWrite <= 1'b0;
			memWb.memRead <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.ctrl.regWrite;
			memWb.memRead <= exMem.ctrl.memRead;
		end
	end

	// Writeback also drives the observation port
	assign wbValid = memWb.regWrite;
	assign wbReg = memWb.destReg;
	assign wbData = memWb.memRead ? memWb.loadData : memWb.aluResult;

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input  wire                    Clk,
	input  wire  mipsPkg::regAddrT rs,
	input  wire  mipsPkg::regAddrT rt,
	input  wire                    writeEn,
	input  wire  mipsPkg::regAddrT writeReg,
	input  wire  mipsPkg::wordT    writeData,
	output mipsPkg::wordT          rsData,
	output mipsPkg::wordT          rtData
);

	mipsPkg::wordT regs [2**mipsPkg::REG_ADDR_WIDTH];

	always_ff @(posedge Clk) begin
		if (writeEn && writeReg != '0) begin
			regs[writeReg] <= writeData;
		end
	end

	// Same-cycle write is visible to the reader
	assign rsData = (rs == '0) ? '0 :
		(writeEn && rs == writeReg) ? writeData : regs[rs];
	assign rtData = (rt == '0) ? '0 :
		(writeEn && rt == writeReg) ? writeData : regs[rt];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, then search the simulation output for the pass message
verilator --binary --top-module cpuTb -f src.f -o cpuSim &&
	./obj_dir/cpuSim | tee /dev/stderr | grep -q "All tests passed" &&
	echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src.f ====
hw/mipsPkg.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/dataMemory.sv
hw/pipelineCpu.sv
verif/cpuTb.sv

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

	logic Clk;
	logic reset;
	mipsPkg::wordT imemData;
	mipsPkg::wordT imemAddr;
	logic wbValid;
	mipsPkg::regAddrT wbReg;
	mipsPkg::wordT wbData;

	mipsPkg::wordT rom [1024];
	int progLen;

	mipsPkg::wordT modelRegs [32];
	mipsPkg::wordT modelMem [256];
	mipsPkg::regAddrT expReg [$];
	mipsPkg::wordT expData [$];

	int testErrors;
	int testCount;
	int failedTests;

	pipelineCpu i_dut (
		.Clk     (Clk),
		.reset   (reset),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

	// Fetches past the ROM see NOPs
	assign imemData = (imemAddr[31:12] == '0) ? rom[imemAddr[11:2]] : '0;

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	function automatic mipsPkg::wordT rFormat(int rs, int rt, int rd, int sh, logic [5:0] fn);
		return {mipsPkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic mipsPkg::wordT iFormat(logic [5:0] op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic mipsPkg::wordT jFormat(int index);
		return {mipsPkg::OP_J, 26'(index)};
	endfunction

	task automatic clearProgram();
		int i;
		for (i = 0; i < 1024; i++) begin
			rom[10'(i)] = '0;
		end
		progLen = 0;
	endtask

	task automatic put(input mipsPkg::wordT w);
		rom[10'(progLen)] = w;
		progLen++;
	endtask

	// Two NOPs behind let the next instruction read the result
	task automatic putSpaced(input mipsPkg::wordT w);
		put(w);
		put('0);
		put('0);
	endtask

	task automatic loadConst(input int r, input mipsPkg::wordT value);
		putSpaced(iFormat(mipsPkg::OP_LUI, 0, r, int'(value[31:16])));
		putSpaced(iFormat(mipsPkg::OP_ORI, r, r, int'(value[15:0])));
	endtask

	// Sequential ISA model stepping one instruction at a time
	task automatic runModel();
		mipsPkg::wordT pc;
		mipsPkg::wordT nextPc;
		mipsPkg::wordT instr;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT sext;
		mipsPkg::wordT zext;
		mipsPkg::wordT addr;
		mipsPkg::wordT res;
		logic writes;
		int dst;
		int steps;
		int r;
		expReg.delete();
		expData.delete();
		for (r = 0; r < 32; r++) begin
			modelRegs[5'(r)] = '0;
		end
		pc = '0;
		steps = 0;
		while (pc < 32'(progLen * 4) && steps < 1000) begin
			instr = rom[pc[11:2]];
			a = modelRegs[instr[25:21]];
			b = modelRegs[instr[20:16]];
			sext = {{16{instr[15]}}, instr[15:0]};
			zext = {16'h0, instr[15:0]};
			addr = a + sext;
			nextPc = pc + 32'd4;
			writes = 1'b1;
			dst = int'(instr[20:16]);
			res = '0;
			case (instr[31:26])
				mipsPkg::OP_RTYPE: begin
					dst = int'(instr[15:11]);
					case (instr[5:0])
						mipsPkg::FN_ADD, mipsPkg::FN_ADDU: res = a + b;
						mipsPkg::FN_SUB, mipsPkg::FN_SUBU: res = a - b;
						mipsPkg::FN_AND:  res = a & b;
						mipsPkg::FN_OR:   res = a | b;
						mipsPkg::FN_XOR:  res = a ^ b;
						mipsPkg::FN_NOR:  res = ~(a | b);
						mipsPkg::FN_SLT:  res = {31'h0, $signed(a) < $signed(b)};
						mipsPkg::FN_SLTU: res = {31'h0, a < b};
						mipsPkg::FN_SLL:  res = b << instr[10:6];
						mipsPkg::FN_SRL:  res = b >> instr[10:6];
						mipsPkg::FN_SRA:  res = 32'($signed(b) >>> instr[10:6]);
						mipsPkg::FN_SLLV: res = b << a[4:0];
						mipsPkg::FN_SRLV: res = b >> a[4:0];
						mipsPkg::FN_SRAV: res = 32'($signed(b) >>> a[4:0]);
						default: writes = 1'b0;
					endcase
				end
				mipsPkg::OP_ADDI, mipsPkg::OP_ADDIU: res = a + sext;
				mipsPkg::OP_SLTI:  res = {31'h0, $signed(a) < $signed(sext)};
				mipsPkg::OP_SLTIU: res = {31'h0, a < sext};
				mipsPkg::OP_ANDI:  res = a & zext;
				mipsPkg::OP_ORI:   res = a | zext;
				mipsPkg::OP_XORI:  res = a ^ zext;
				mipsPkg::OP_LUI:   res = {instr[15:0], 16'h0};
				mipsPkg::OP_LW:    res = modelMem[addr[9:2]];
				mipsPkg::OP_SW: begin
					modelMem[addr[9:2]] = b;
					writes = 1'b0;
				end
				mipsPkg::OP_BEQ: begin
					writes = 1'b0;
					if (a == b) begin
						nextPc = pc + 32'd4 + {sext[29:0], 2'b00};
					end
				end
				mipsPkg::OP_BNE: begin
					writes = 1'b0;
					if (a != b) begin
						nextPc = pc + 32'd4 + {sext[29:0], 2'b00};
					end
				end
				mipsPkg::OP_J: begin
					writes = 1'b0;
					nextPc = {nextPc[31:28], instr[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			if (writes && dst != 0) begin // r0 stays zero
				modelRegs[5'(dst)] = res;
				expReg.push_back(5'(dst));
				expData.push_back(res);
			end
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		repeat (5) @(negedge Clk);
		reset = 1'b0;
	endtask

	task automatic collectWrites();
		int k;
		int i;
		int waitCount;
		logic timedOut;
		timedOut = 1'b0;
		k = 0;
		while (k < expReg.size() && !timedOut) begin
			waitCount = 0;
			while (wbValid !== 1'b1 && waitCount < 200) begin
				@(negedge Clk);
				waitCount++;
			end
			if (wbValid !== 1'b1) begin
				$display("Timed out waiting for writeback %0d of %0d", k + 1, expReg.size());
				testErrors++;
				timedOut = 1'b1;
			end else begin
				assert (wbReg === expReg[k]) else begin
					$display("Mismatch wbReg (event %0d): got %h expected %h", k, wbReg, expReg[k]);
					testErrors++;
				end
				assert (wbData === expData[k]) else begin
					$display("Mismatch wbData (event %0d): got %h expected %h", k, wbData,
						expData[k]);
					testErrors++;
				end
				k++;
				@(negedge Clk);
			end
		end
		// Nothing more may retire after the last event
		for (i = 0; i < 8; i++) begin
			assert (wbValid !== 1'b1) else begin
				$display("Unexpected extra writeback to r%0d", wbReg);
				testErrors++;
			end
			@(negedge Clk);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (testErrors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, testErrors);
			failedTests++;
		end
		testErrors = 0;
	endtask

	task automatic runProgram(input string name);
		runModel();
		applyReset();
		collectWrites();
		finishTest(name);
	endtask

	task automatic resetTest();
		int i;
		clearProgram();
		applyReset();
		for (i = 0; i < 20; i++) begin
			assert (wbValid === 1'b0) else begin
				$display("Mismatch wbValid: got %h expected %h", wbValid, 1'b0);
				testErrors++;
			end
			assert (imemAddr === 32'(i * 4)) else begin
				$display("Mismatch imemAddr: got %h expected %h", imemAddr, 32'(i * 4));
				testErrors++;
			end
			@(negedge Clk);
		end
		finishTest("Reset and sequential fetch");
	endtask

	task automatic aluOpsTest();
		logic [5:0] fns [16];
		int i;
		fns = '{mipsPkg::FN_ADD, mipsPkg::FN_ADDU, mipsPkg::FN_SUB, mipsPkg::FN_SUBU,
			mipsPkg::FN_AND, mipsPkg::FN_OR, mipsPkg::FN_XOR, mipsPkg::FN_NOR,
			mipsPkg::FN_SLT, mipsPkg::FN_SLTU, mipsPkg::FN_SLL, mipsPkg::FN_SRL,
			mipsPkg::FN_SRA, mipsPkg::FN_SLLV, mipsPkg::FN_SRLV, mipsPkg::FN_SRAV};
		clearProgram();
		loadConst(1, 32'h8000_0000 | $urandom()); // Negative so SRA and SRL differ
		loadConst(2, 32'h7fff_ffff & $urandom()); // Positive so SLT and SLTU differ
		loadConst(3, $urandom());
		// Sources are settled so these run back to back
		for (i = 0; i < 16; i++) begin
			if (fns[4'(i)] == mipsPkg::FN_SLL || fns[4'(i)] == mipsPkg::FN_SRL
				|| fns[4'(i)] == mipsPkg::FN_SRA) begin
				put(rFormat(0, 1, 4 + i, int'($urandom_range(31, 0)), fns[4'(i)]));
			end else if (fns[4'(i)] == mipsPkg::FN_SLLV || fns[4'(i)] == mipsPkg::FN_SRLV
				|| fns[4'(i)] == mipsPkg::FN_SRAV) begin
				put(rFormat(3, 1, 4 + i, 0, fns[4'(i)]));
			end else begin
				put(rFormat(1, 2, 4 + i, 0, fns[4'(i)]));
			end
		end
		put(rFormat(1, 1, 20, 0, mipsPkg::FN_SLT)); // Equal operands
		put(rFormat(1, 1, 21, 0, mipsPkg::FN_SUB));
		runProgram("R-type and shifts");
	endtask

	task automatic immOpsTest();
		clearProgram();
		loadConst(1, $urandom());
		loadConst(2, 32'h8000_0000 | $urandom());
		put(iFormat(mipsPkg::OP_ADDI, 1, 10, -16));
		put(iFormat(mipsPkg::OP_ADDIU, 1, 11, 32767));
		put(iFormat(mipsPkg::OP_ANDI, 1, 12, 'hf0f0));
		put(iFormat(mipsPkg::OP_ORI, 2, 13, 'h8001));
		put(iFormat(mipsPkg::OP_XORI, 1, 14, 'hffff));
		put(iFormat(mipsPkg::OP_SLTI, 2, 15, -1));
		put(iFormat(mipsPkg::OP_SLTIU, 1, 16, -1));
		put(iFormat(mipsPkg::OP_SLTI, 2, 17, 5));
		put(iFormat(mipsPkg::OP_SLTIU, 2, 18, 'h10));
		put(iFormat(mipsPkg::OP_LUI, 0, 19, 'habcd));
		put(iFormat(mipsPkg::OP_ADDI, 1, 0, 7)); // Targets r0 and makes no event
		put(iFormat(mipsPkg::OP_LUI, 0, 0, 'h1));
		put(iFormat(mipsPkg::OP_ADDIU, 0, 20, -2));
		put(iFormat(mipsPkg::OP_XORI, 2, 21, 'h8000));
		runProgram("Immediate operations");
	endtask

	task automatic memOpsTest();
		clearProgram();
		putSpaced(iFormat(mipsPkg::OP_ORI, 0, 1, 'h100));
		loadConst(2, $urandom());
		loadConst(3, $urandom());
		put(iFormat(mipsPkg::OP_SW, 1, 2, 0));
		put(iFormat(mipsPkg::OP_SW, 1, 3, 8));
		put(iFormat(mipsPkg::OP_SW, 1, 2, -4));
		put(iFormat(mipsPkg::OP_LW, 1, 4, 0));
		put(iFormat(mipsPkg::OP_LW, 1, 5, 8));
		put(iFormat(mipsPkg::OP_LW, 1, 6, -4));
		put(iFormat(mipsPkg::OP_SW, 1, 3, 0)); // Overwrite and read straight back
		put(iFormat(mipsPkg::OP_LW, 1, 7, 0));
		runProgram("Store and load");
	endtask

	task automatic branchTest();
		int loopStart;
		clearProgram();
		loadConst(1, $urandom());
		putSpaced(rFormat(1, 0, 2, 0, mipsPkg::FN_ADDU));
		putSpaced(iFormat(mipsPkg::OP_XORI, 1, 3, 1));
		putSpaced(iFormat(mipsPkg::OP_ORI, 0, 23, 3));
		put(iFormat(mipsPkg::OP_BEQ, 1, 2, 3)); // Taken
		put(iFormat(mipsPkg::OP_ADDI, 0, 5, 1));
		put(iFormat(mipsPkg::OP_ADDI, 0, 6, 2));
		put(iFormat(mipsPkg::OP_ADDI, 0, 7, 3));
		put(iFormat(mipsPkg::OP_ADDI, 0, 8, 4));
		put(iFormat(mipsPkg::OP_BNE, 1, 3, 3)); // Taken
		put(iFormat(mipsPkg::OP_ADDI, 0, 9, 5));
		put(iFormat(mipsPkg::OP_ADDI, 0, 10, 6));
		put(iFormat(mipsPkg::OP_ADDI, 0, 11, 7));
		put(iFormat(mipsPkg::OP_ADDI, 0, 12, 8));
		put(iFormat(mipsPkg::OP_BEQ, 1, 3, 2)); // Not taken
		put(iFormat(mipsPkg::OP_ADDI, 0, 13, 9));
		put(iFormat(mipsPkg::OP_ADDI, 0, 14, 10));
		put(iFormat(mipsPkg::OP_ADDI, 0, 15, 11));
		put(iFormat(mipsPkg::OP_BNE, 1, 2, 2)); // Not taken
		put(iFormat(mipsPkg::OP_ADDI, 0, 16, 12));
		put(iFormat(mipsPkg::OP_ADDI, 0, 17, 13));
		put(iFormat(mipsPkg::OP_ADDI, 0, 18, 14));
		put(jFormat(progLen + 3));
		put(iFormat(mipsPkg::OP_ADDI, 0, 20, 15));
		put(iFormat(mipsPkg::OP_ADDI, 0, 21, 16));
		put(iFormat(mipsPkg::OP_ADDI, 0, 22, 17));
		// Countdown loop with a backward branch
		loopStart = progLen;
		put(iFormat(mipsPkg::OP_ADDI, 23, 23, -1));
		put('0);
		put('0);
		put(iFormat(mipsPkg::OP_BNE, 23, 0, loopStart - progLen - 1));
		put(iFormat(mipsPkg::OP_ADDI, 0, 24, 18));
		put(iFormat(mipsPkg::OP_ADDI, 0, 25, 19));
		runProgram("Branches and jump");
	endtask

	task automatic latencyTest();
		int waitCount;
		clearProgram();
		put('0);
		put('0);
		put('0);
		put(iFormat(mipsPkg::OP_ADDI, 0, 3, 'h1234));
		applyReset();
		waitCount = 0;
		while (imemAddr !== 32'd12 && waitCount < 200) begin
			@(negedge Clk);
			waitCount++;
		end
		if (imemAddr !== 32'd12) begin
			$display("Timed out waiting for the ADDI to be fetched");
			testErrors++;
		end else begin
			@(negedge Clk);
			waitCount = 1;
			while (wbValid !== 1'b1 && waitCount < 200) begin
				@(negedge Clk);
				waitCount++;
			end
			if (wbValid !== 1'b1) begin
				$display("Timed out waiting for the ADDI writeback");
				testErrors++;
			end else begin
				assert (waitCount == 4) else begin
					$display("Mismatch writeback latency: got %h expected %h", waitCount, 4);
					testErrors++;
				end
				assert (wbReg === 5'd3) else begin
					$display("Mismatch wbReg: got %h expected %h", wbReg, 5'd3);
					testErrors++;
				end
				assert (wbData === 32'h1234) else begin
					$display("Mismatch wbData: got %h expected %h", wbData, 32'h1234);
					testErrors++;
				end
			end
		end
		finishTest("Writeback latency");
	endtask

	initial begin
		reset = 1'b1;
		testErrors = 0;
		testCount = 0;
		failedTests = 0;
		void'($urandom(32'h5adf_f394));
		resetTest();
		aluOpsTest();
		immOpsTest();
		memOpsTest();
		branchTest();
		latencyTest();
		$display("%0d tests run, %0d failed", testCount, failedTests);
		if (failedTests == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
